/* common/axi_mem_pkg.sv */
package axi_mem_pkg;

  // bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W = 4;
  localparam int LEN_W = 8;

  // address map
  localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;
  localparam int MEM_WORDS = 1024;
  localparam int MEM_AW = 10;
  localparam logic [ADDR_W-1:0] SERIAL_ADDR = 32'ha000_03f8;

  // acceptance gating
  localparam bit STALL_EN = 1'b1;
  localparam int LFSR_W = 20;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 20'd101;

  // response codes
  localparam logic [1:0] RESP_OKAY = 2'd0;
  localparam logic [1:0] RESP_DECERR = 2'd3;

  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_SERIAL,
    TGT_NONE
  } target_e;

  // r channel beat
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } rd_beat_t;

  // b channel response
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } wr_resp_t;

endpackage

/* common/mem_op_if.sv */
interface mem_op_if import axi_mem_pkg::*; ();

  logic                valid;
  logic                is_write;
  target_e             target;
  logic [MEM_AW-1:0]   widx;
  logic [ID_W-1:0]     id;
  logic [DATA_W-1:0]   wdata;
  logic [STRB_W-1:0]   wstrb;

  modport decode (
    output valid,
    output is_write,
    output target,
    output widx,
    output id,
    output wdata,
    output wstrb
  );

  modport execute (
    input valid,
    input is_write,
    input target,
    input widx,
    input id,
    input wdata,
    input wstrb
  );

endinterface

/* axi_mem/axi_req_decode.sv */
module axi_req_decode import axi_mem_pkg::*; (
  input  logic              clk,
  input  logic              arst_n_i,

  input  logic              arvalid_i,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic [ID_W-1:0]   arid_i,
  input  logic [LEN_W-1:0]  arlen_i,
  output logic              arready_o,

  input  logic              awvalid_i,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic [ID_W-1:0]   awid_i,
  input  logic [LEN_W-1:0]  awlen_i,
  output logic              awready_o,

  input  logic              wvalid_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  input  logic              wlast_i,
  output logic              wready_o,

  input  logic              resp_done_i,
  mem_op_if.decode          op
);

  logic [LFSR_W-1:0] lfsr_q;
  logic              live_q;
  logic              busy_q;
  logic              stall_ok;
  logic              can_accept;
  logic              ar_acc;
  logic              aw_acc;
  logic              accept;
  logic [ADDR_W-1:0] req_addr;
  logic [ADDR_W-1:0] req_off;
  target_e           req_tgt;

  // pseudo-random back-pressure
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[LFSR_W-1] ^ lfsr_q[LFSR_W-2]};
    end
  end

  assign stall_ok = STALL_EN ? lfsr_q[LFSR_W-1] : 1'b1;

  // one transaction in flight, busy until its response is taken
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      live_q <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (resp_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign can_accept = live_q && !busy_q && stall_ok;

  // reads win over writes
  assign arready_o = can_accept;
  assign awready_o = can_accept && awvalid_i && wvalid_i && !arvalid_i;
  assign wready_o  = awready_o;

  assign ar_acc = arvalid_i && arready_o;
  assign aw_acc = awvalid_i && awready_o;
  assign accept = ar_acc || aw_acc;

  assign req_addr = arvalid_i ? araddr_i : awaddr_i;

  // unsigned wrap makes addresses below the base fall out of range
  always_comb begin
    req_off = req_addr - MEM_BASE;
    if (req_off < ADDR_W'(MEM_WORDS * STRB_W)) begin
      req_tgt = TGT_MEM;
    end else if (req_addr == SERIAL_ADDR) begin
      req_tgt = TGT_SERIAL;
    end else begin
      req_tgt = TGT_NONE;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op.is_write <= aw_acc;
      op.target   <= req_tgt;
      op.widx     <= req_off[$clog2(STRB_W) +: MEM_AW];
      op.id       <= ar_acc ? arid_i : awid_i;
      op.wdata    <= wdata_i;
      op.wstrb    <= wstrb_i;
    end
  end

  // single beats only
  a_arlen_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
    ar_acc |-> arlen_i == '0);

  a_awlen_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
    aw_acc |-> awlen_i == '0);

  a_wlast_on_accept: assert property (@(posedge clk) disable iff (!arst_n_i)
    aw_acc |-> wlast_i);

endmodule

/* axi_mem/mem_execute.sv */
module mem_execute import axi_mem_pkg::*; (
  input  logic        clk,
  input  logic        arst_n_i,

  mem_op_if.execute   op,

  output logic        rd_load_o,
  output rd_beat_t    rd_beat_o,
  output logic        wr_load_o,
  output wr_resp_t    wr_resp_o,

  output logic [7:0]  uart_data_o,
  output logic        uart_valid_o
);

  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic [ID_W-1:0]   id_q;
  target_e           tgt_q;
  logic              mem_wr;
  logic              uart_wr;
  logic [1:0]        resp;

  assign mem_wr  = op.valid && op.is_write && (op.target == TGT_MEM);
  assign uart_wr = op.valid && op.is_write && (op.target == TGT_SERIAL);

  // ram with per-byte write enables, synchronous read
  always_ff @(posedge clk) begin
    if (mem_wr) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (op.wstrb[b]) begin
          mem_q[op.widx][b*8 +: 8] <= op.wdata[b*8 +: 8];
        end
      end
    end
    rdata_q <= mem_q[op.widx];
  end

  // response fields follow the ram read by one cycle
  always_ff @(posedge clk) begin
    if (op.valid) begin
      id_q  <= op.id;
      tgt_q <= op.target;
    end
    if (uart_wr) begin
      uart_data_o <= op.wdata[7:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_load_o    <= 1'b0;
      wr_load_o    <= 1'b0;
      uart_valid_o <= 1'b0;
    end else begin
      rd_load_o    <= op.valid && !op.is_write;
      wr_load_o    <= op.valid && op.is_write;
      uart_valid_o <= uart_wr;
    end
  end

  assign resp = (tgt_q == TGT_NONE) ? RESP_DECERR : RESP_OKAY;

  // serial and unmapped reads return zero
  always_comb begin
    rd_beat_o.id   = id_q;
    rd_beat_o.data = (tgt_q == TGT_MEM) ? rdata_q : '0;
    rd_beat_o.resp = resp;
  end

  always_comb begin
    wr_resp_o.id   = id_q;
    wr_resp_o.resp = resp;
  end

  // id_q and tgt_q hold a single operation
  a_one_op: assert property (@(posedge clk) disable iff (!arst_n_i)
    op.valid |=> !op.valid);

endmodule

/* axi_mem/axi_resp_channel.sv */
module axi_resp_channel #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n_i,

  input  logic     load_i,
  input  payload_t payload_i,
  input  logic     ready_i,

  output logic     valid_o,
  output payload_t payload_o,
  output logic     done_o
);

  logic     valid_q;
  payload_t payload_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (load_i) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      payload_q <= payload_i;
    end
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;
  assign done_o    = valid_q && ready_i;

  // held under back-pressure
  a_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(payload_o));

  // decode keeps busy until done, so no overlap
  a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n_i)
    load_i |-> !valid_o);

endmodule

/* rtl/axi_mem_top.sv */
module axi_mem_top import axi_mem_pkg::*; (
  input  logic              clk,
  input  logic              arst_n_i,

  input  logic              arvalid_i,
  output logic              arready_o,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic [ID_W-1:0]   arid_i,
  input  logic [LEN_W-1:0]  arlen_i,

  output logic              rvalid_o,
  input  logic              rready_i,
  output logic [ID_W-1:0]   rid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic [1:0]        rresp_o,
  output logic              rlast_o,

  input  logic              awvalid_i,
  output logic              awready_o,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic [ID_W-1:0]   awid_i,
  input  logic [LEN_W-1:0]  awlen_i,

  input  logic              wvalid_i,
  output logic              wready_o,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  input  logic              wlast_i,

  output logic              bvalid_o,
  input  logic              bready_i,
  output logic [ID_W-1:0]   bid_o,
  output logic [1:0]        bresp_o,

  output logic [7:0]        uart_data_o,
  output logic              uart_valid_o
);

  mem_op_if op_if ();

  logic     rd_load;
  rd_beat_t rd_beat;
  rd_beat_t r_payload;
  logic     r_done;
  logic     wr_load;
  wr_resp_t wr_resp;
  wr_resp_t b_payload;
  logic     b_done;

  axi_req_decode decode (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .arvalid_i   (arvalid_i),
    .araddr_i    (araddr_i),
    .arid_i      (arid_i),
    .arlen_i     (arlen_i),
    .arready_o   (arready_o),
    .awvalid_i   (awvalid_i),
    .awaddr_i    (awaddr_i),
    .awid_i      (awid_i),
    .awlen_i     (awlen_i),
    .awready_o   (awready_o),
    .wvalid_i    (wvalid_i),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wlast_i     (wlast_i),
    .wready_o    (wready_o),
    .resp_done_i (r_done | b_done),
    .op          (op_if.decode)
  );

  mem_execute execute (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .op           (op_if.execute),
    .rd_load_o    (rd_load),
    .rd_beat_o    (rd_beat),
    .wr_load_o    (wr_load),
    .wr_resp_o    (wr_resp),
    .uart_data_o  (uart_data_o),
    .uart_valid_o (uart_valid_o)
  );

  axi_resp_channel #(.payload_t(rd_beat_t)) r_chan (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .load_i    (rd_load),
    .payload_i (rd_beat),
    .ready_i   (rready_i),
    .valid_o   (rvalid_o),
    .payload_o (r_payload),
    .done_o    (r_done)
  );

  axi_resp_channel #(.payload_t(wr_resp_t)) b_chan (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .load_i    (wr_load),
    .payload_i (wr_resp),
    .ready_i   (bready_i),
    .valid_o   (bvalid_o),
    .payload_o (b_payload),
    .done_o    (b_done)
  );

  assign rid_o   = r_payload.id;
  assign rdata_o = r_payload.data;
  assign rresp_o = r_payload.resp;
  assign rlast_o = 1'b1;

  assign bid_o   = b_payload.id;
  assign bresp_o = b_payload.resp;

endmodule

/* tb/axi_mem_checker.sv */
module axi_mem_checker import axi_mem_pkg::*; (
  input logic              clk,
  input logic              arst_n_i,
  input logic              arvalid_i,
  input logic              arready_i,
  input logic [ADDR_W-1:0] araddr_i,
  input logic [ID_W-1:0]   arid_i,
  input logic              rvalid_i,
  input logic              rready_i,
  input logic [ID_W-1:0]   rid_i,
  input logic [DATA_W-1:0] rdata_i,
  input logic [1:0]        rresp_i,
  input logic              rlast_i,
  input logic              awvalid_i,
  input logic              awready_i,
  input logic [ADDR_W-1:0] awaddr_i,
  input logic [ID_W-1:0]   awid_i,
  input logic              wvalid_i,
  input logic              wready_i,
  input logic [DATA_W-1:0] wdata_i,
  input logic [STRB_W-1:0] wstrb_i,
  input logic              bvalid_i,
  input logic              bready_i,
  input logic [ID_W-1:0]   bid_i,
  input logic [1:0]        bresp_i,
  input logic [7:0]        uart_data_i,
  input logic              uart_valid_i
);

  logic [DATA_W-1:0]        ref_mem [MEM_WORDS];
  rd_beat_t                 exp_r [$];
  wr_resp_t                 exp_b [$];
  logic [7:0]               exp_uart [$];
  string                    cur_test = "reset";
  int                       test_errs = 0;
  int                       error_count = 0;
  int                       tests_ok = 0;
  int                       tests_bad = 0;
  int                       outstanding = 0;
  logic                     r_hold = 1'b0;
  logic                     b_hold = 1'b0;
  logic [ID_W+DATA_W+1:0]   r_seen;
  logic [ID_W+1:0]          b_seen;

  // address map as seen by the master
  function automatic target_e target_of(input logic [ADDR_W-1:0] addr);
    if (addr >= MEM_BASE && addr <= MEM_BASE + ADDR_W'(MEM_WORDS * 8 - 1)) begin
      return TGT_MEM;
    end
    return (addr == SERIAL_ADDR) ? TGT_SERIAL : TGT_NONE;
  endfunction

  function automatic rd_beat_t expected_read(input logic [ADDR_W-1:0] addr,
                                             input logic [ID_W-1:0] id);
    rd_beat_t beat;
    int       idx;
    idx = (addr - MEM_BASE) >> 3;
    beat.id = id;
    beat.data = (target_of(addr) == TGT_MEM) ? ref_mem[idx] : '0;
    beat.resp = (target_of(addr) == TGT_NONE) ? RESP_DECERR : RESP_OKAY;
    return beat;
  endfunction

  // merges the strobed bytes into the image
  function automatic wr_resp_t apply_write(input logic [ADDR_W-1:0] addr,
                                           input logic [ID_W-1:0] id,
                                           input logic [DATA_W-1:0] data,
                                           input logic [STRB_W-1:0] strb);
    wr_resp_t resp;
    int       idx;
    idx = (addr - MEM_BASE) >> 3;
    resp.id = id;
    resp.resp = (target_of(addr) == TGT_NONE) ? RESP_DECERR : RESP_OKAY;
    if (target_of(addr) == TGT_MEM) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb[b]) begin
          ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end
    return resp;
  endfunction

  task automatic report_fault(input string msg);
    $display("[ERROR] %s: %s", cur_test, msg);
    test_errs++;
    error_count++;
  endtask

  task automatic compare_field(input string field, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, field, exp, act);
      test_errs++;
      error_count++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (exp_r.size() != 0 || exp_b.size() != 0 || outstanding != 0) begin
      report_fault("an accepted request never got its response");
    end
    if (exp_uart.size() != 0) begin
      report_fault("a serial write produced no console strobe");
    end
    exp_r.delete();
    exp_b.delete();
    exp_uart.delete();
    outstanding = 0;
    if (test_errs == 0) begin
      tests_ok++;
      $display("%s: ok", cur_test);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic report_summary();
    $display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
             tests_ok, tests_bad, error_count);
  endtask

  always @(posedge clk) begin : watch
    rd_beat_t exp_rd;
    wr_resp_t exp_wr;
    if (arst_n_i) begin
      if (arvalid_i && arready_i) begin
        if (outstanding != 0) begin
          report_fault("read accepted while a response was still pending");
        end
        exp_r.push_back(expected_read(araddr_i, arid_i));
        outstanding++;
      end
      if (awvalid_i && awready_i) begin
        if (outstanding != 0 || arvalid_i) begin
          report_fault("write accepted while a read or a response was pending");
        end
        if (!(wvalid_i && wready_i)) begin
          report_fault("write address accepted without its write data");
        end
        if (target_of(awaddr_i) == TGT_SERIAL) begin
          exp_uart.push_back(wdata_i[7:0]);
        end
        exp_b.push_back(apply_write(awaddr_i, awid_i, wdata_i, wstrb_i));
        outstanding++;
      end
      if (rvalid_i && rready_i) begin
        if (exp_r.size() == 0) begin
          report_fault("read response without an accepted read");
        end else begin
          exp_rd = exp_r.pop_front();
          compare_field("rid", exp_rd.id, rid_i);
          compare_field("rdata", exp_rd.data, rdata_i);
          compare_field("rresp", exp_rd.resp, rresp_i);
        end
        if (!rlast_i) begin
          report_fault("rlast low on a read response");
        end
        outstanding--;
      end
      if (bvalid_i && bready_i) begin
        if (exp_b.size() == 0) begin
          report_fault("write response without an accepted write");
        end else begin
          exp_wr = exp_b.pop_front();
          compare_field("bid", exp_wr.id, bid_i);
          compare_field("bresp", exp_wr.resp, bresp_i);
        end
        outstanding--;
      end
      if (uart_valid_i) begin
        if (exp_uart.size() == 0) begin
          report_fault("console strobe without a serial write");
        end else begin
          compare_field("uart_data", exp_uart.pop_front(), uart_data_i);
        end
      end
      // responses must hold while the master stalls
      if (r_hold && (!rvalid_i || {rid_i, rdata_i, rresp_i} !== r_seen)) begin
        report_fault("read response dropped or changed while rready was low");
      end
      if (b_hold && (!bvalid_i || {bid_i, bresp_i} !== b_seen)) begin
        report_fault("write response dropped or changed while bready was low");
      end
      r_hold <= rvalid_i && !rready_i;
      b_hold <= bvalid_i && !bready_i;
      r_seen <= {rid_i, rdata_i, rresp_i};
      b_seen <= {bid_i, bresp_i};
    end
  end

endmodule

/* tb/tb_axi_mem.sv */
module tb_axi_mem import axi_mem_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  // transactions issued over all six tests
  localparam int NUM_TXN = 69;
  localparam int WATCHDOG_CYCLES = NUM_TXN * 200 + 1000;

  logic              clk;
  logic              arst_n_i;
  logic              arvalid_i;
  logic              arready_o;
  logic [ADDR_W-1:0] araddr_i;
  logic [ID_W-1:0]   arid_i;
  logic [LEN_W-1:0]  arlen_i;
  logic              rvalid_o;
  logic              rready_i;
  logic [ID_W-1:0]   rid_o;
  logic [DATA_W-1:0] rdata_o;
  logic [1:0]        rresp_o;
  logic              rlast_o;
  logic              awvalid_i;
  logic              awready_o;
  logic [ADDR_W-1:0] awaddr_i;
  logic [ID_W-1:0]   awid_i;
  logic [LEN_W-1:0]  awlen_i;
  logic              wvalid_i;
  logic              wready_o;
  logic [DATA_W-1:0] wdata_i;
  logic [STRB_W-1:0] wstrb_i;
  logic              wlast_i;
  logic              bvalid_o;
  logic              bready_i;
  logic [ID_W-1:0]   bid_o;
  logic [1:0]        bresp_o;
  logic [7:0]        uart_data_o;
  logic              uart_valid_o;

  integer            seed;
  logic [ID_W-1:0]   next_id;
  logic [ADDR_W-1:0] addr;
  logic [STRB_W-1:0] strb;
  logic [ADDR_W-1:0] written [$];
  logic [ADDR_W-1:0] bad_addr [4] = '{32'h0000_1000, 32'h8000_2000, 32'h7fff_fff8,
                                      32'ha000_0400};

  axi_mem_top axi_mem_top_inst (.*);

  axi_mem_checker chk (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .arvalid_i    (arvalid_i),
    .arready_i    (arready_o),
    .araddr_i     (araddr_i),
    .arid_i       (arid_i),
    .rvalid_i     (rvalid_o),
    .rready_i     (rready_i),
    .rid_i        (rid_o),
    .rdata_i      (rdata_o),
    .rresp_i      (rresp_o),
    .rlast_i      (rlast_o),
    .awvalid_i    (awvalid_i),
    .awready_i    (awready_o),
    .awaddr_i     (awaddr_i),
    .awid_i       (awid_i),
    .wvalid_i     (wvalid_i),
    .wready_i     (wready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .bvalid_i     (bvalid_o),
    .bready_i     (bready_i),
    .bid_i        (bid_o),
    .bresp_i      (bresp_o),
    .uart_data_i  (uart_data_o),
    .uart_valid_i (uart_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [ADDR_W-1:0] rand_mem_addr();
    logic [MEM_AW-1:0] idx;
    idx = $random(seed);
    return MEM_BASE + {idx, 3'b000};
  endfunction

  function automatic logic [DATA_W-1:0] rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic issue_read(input logic [ADDR_W-1:0] a);
    arvalid_i <= 1'b1;
    araddr_i  <= a;
    arid_i    <= next_id;
    next_id++;
  endtask

  task automatic issue_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                             input logic [STRB_W-1:0] s);
    awvalid_i <= 1'b1;
    awaddr_i  <= a;
    awid_i    <= next_id;
    wvalid_i  <= 1'b1;
    wdata_i   <= d;
    wstrb_i   <= s;
    next_id++;
  endtask

  // returns on the edge where the request handshake happens
  task automatic wait_accept(input bit is_read);
    do @(posedge clk); while (!(is_read ? arready_o : awready_o));
    if (is_read) begin
      arvalid_i <= 1'b0;
    end else begin
      awvalid_i <= 1'b0;
      wvalid_i  <= 1'b0;
    end
  endtask

  // ready held low for hold cycles once the response is valid
  task automatic await_resp(input bit is_read, input int hold);
    if (is_read) begin
      rready_i <= (hold == 0);
    end else begin
      bready_i <= (hold == 0);
    end
    do @(posedge clk); while (!(is_read ? rvalid_o : bvalid_o));
    if (hold > 0) begin
      repeat (hold) @(posedge clk);
      if (is_read) begin
        rready_i <= 1'b1;
      end else begin
        bready_i <= 1'b1;
      end
      @(posedge clk);
    end
    rready_i <= 1'b0;
    bready_i <= 1'b0;
  endtask

  task automatic write_txn(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                           input logic [STRB_W-1:0] s);
    @(posedge clk);
    issue_write(a, d, s);
    wait_accept(1'b0);
    await_resp(1'b0, 0);
  endtask

  task automatic read_txn(input logic [ADDR_W-1:0] a);
    @(posedge clk);
    issue_read(a);
    wait_accept(1'b1);
    await_resp(1'b1, 0);
  endtask

  // read and write presented in the same cycle
  task automatic race_txn(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    @(posedge clk);
    issue_read(a);
    issue_write(a, d, '1);
    wait_accept(1'b1);
    await_resp(1'b1, 0);
    wait_accept(1'b0);
    await_resp(1'b0, 0);
  endtask

  // next read waits at the port while the write response is stalled
  task automatic pressure_txn(input logic [ADDR_W-1:0] a, input int b_hold, input int r_hold);
    @(posedge clk);
    issue_write(a, rand_data(), '1);
    wait_accept(1'b0);
    issue_read(a);
    await_resp(1'b0, b_hold);
    wait_accept(1'b1);
    await_resp(1'b1, r_hold);
  endtask

  task automatic close_test();
    repeat (3) @(posedge clk);
    @(negedge clk);
    chk.finish_test();
  endtask

  initial begin
    seed      = 32'h136b_8147;
    next_id   = '0;
    arst_n_i  = 1'b0;
    arvalid_i = 1'b0;
    araddr_i  = '0;
    arid_i    = '0;
    arlen_i   = '0;
    rready_i  = 1'b0;
    awvalid_i = 1'b0;
    awaddr_i  = '0;
    awid_i    = '0;
    awlen_i   = '0;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wlast_i   = 1'b1;
    bready_i  = 1'b0;
    repeat (5) @(posedge clk);
    arst_n_i <= 1'b1;

    chk.start_test("full_strobe");
    for (int i = 0; i < 8; i++) begin
      addr = rand_mem_addr();
      written.push_back(addr);
      write_txn(addr, rand_data(), '1);
    end
    foreach (written[i]) begin
      read_txn(written[i]);
    end
    close_test();

    chk.start_test("partial_strobe");
    for (int i = 0; i < 6; i++) begin
      addr = rand_mem_addr();
      written.push_back(addr);
      strb = STRB_W'(1 + {$random(seed)} % 254);
      write_txn(addr, rand_data(), '1);
      write_txn(addr, rand_data(), strb);
      read_txn(addr);
    end
    close_test();

    chk.start_test("serial_port");
    // ram word that shares its low address bits with the serial port
    write_txn(MEM_BASE + 32'h3f8, rand_data(), '1);
    write_txn(SERIAL_ADDR, rand_data(), '1);
    read_txn(SERIAL_ADDR);
    read_txn(MEM_BASE + 32'h3f8);
    read_txn(written[0]);
    close_test();

    chk.start_test("decode_error");
    write_txn(MEM_BASE, rand_data(), '1);
    foreach (bad_addr[i]) begin
      write_txn(bad_addr[i], rand_data(), '1);
    end
    foreach (bad_addr[i]) begin
      read_txn(bad_addr[i]);
    end
    read_txn(MEM_BASE);
    close_test();

    chk.start_test("read_before_write");
    for (int i = 0; i < 4; i++) begin
      race_txn(written[i], rand_data());
    end
    close_test();

    chk.start_test("back_pressure");
    for (int i = 0; i < 6; i++) begin
      pressure_txn(written[i], 1 + {$random(seed)} % 8, 1 + {$random(seed)} % 8);
    end
    close_test();

    chk.report_summary();
    if (chk.error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

/* project.f */
common/axi_mem_pkg.sv
common/mem_op_if.sv
axi_mem/axi_req_decode.sv
axi_mem/mem_execute.sv
axi_mem/axi_resp_channel.sv
rtl/axi_mem_top.sv
tb/axi_mem_checker.sv
tb/tb_axi_mem.sv

/* Bender.yml */
package:
  name: axi_mem

sources:
  - common/axi_mem_pkg.sv
  - common/mem_op_if.sv
  - axi_mem/axi_req_decode.sv
  - axi_mem/mem_execute.sv
  - axi_mem/axi_resp_channel.sv
  - rtl/axi_mem_top.sv
  - target: test
    files:
      - tb/axi_mem_checker.sv
      - tb/tb_axi_mem.sv
